//--- logic/fbuf_pkg.sv
package fbuf_pkg;

    // Host data half-word, one pipe transfer
    typedef logic [15:0] half_t;

    // Buffer word as seen by the sweep side
    typedef logic [31:0] word_t;

    // IEEE-754 single-precision fields, overlays word_t
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp32_t;

    // Exponent codes with special meaning
    localparam logic [7:0] EXP_ZERO = 8'd0;
    localparam logic [7:0] EXP_MAX_FINITE = 8'd254;
    localparam logic [7:0] EXP_INF_NAN = 8'd255;

    // Host write strobe and its data travel together
    typedef struct packed {
        logic  write;
        half_t data;
    } pipe_in_t;

    // Sweep FSM
    // READ and WRITE alternate once per word
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } sweep_state_e;

endpackage

//--- logic/fp_double.sv
`timescale 1ns/1ps

module fp_double (
    input  fbuf_pkg::word_t value,
    output fbuf_pkg::word_t doubled
);

    fbuf_pkg::fp32_t in_fp;
    fbuf_pkg::fp32_t out_fp;

    assign in_fp = value;

    always_comb begin
        // Sign and mantissa carry over by default
        out_fp = in_fp;
        case (in_fp.exponent)
            // Zero and denormals pass unchanged
            fbuf_pkg::EXP_ZERO: begin
                out_fp = in_fp;
            end
            // Inf and NaN pass unchanged
            fbuf_pkg::EXP_INF_NAN: begin
                out_fp = in_fp;
            end
            // Overflow to infinity
            fbuf_pkg::EXP_MAX_FINITE: begin
                out_fp.exponent = fbuf_pkg::EXP_INF_NAN;
                out_fp.mantissa = '0;
            end
            // Normal case, times two is exponent plus one
            default: begin
                out_fp.exponent = in_fp.exponent + 8'd1;
            end
        endcase
    end

    assign doubled = out_fp;

endmodule

//--- logic/fbuf_ram.sv
`timescale 1ns/1ps

module fbuf_ram #(
    parameter int WORD_ADDR_W = 9
) (
    input  logic                   a_clk,

    // Host side, one half-word per access
    input  logic                   host_wr,
    input  logic [WORD_ADDR_W:0]   host_addr,
    input  fbuf_pkg::half_t        host_din,
    output fbuf_pkg::half_t        host_dout,

    // Sweep side, one full word per access
    input  logic                   sweep_wr,
    input  logic [WORD_ADDR_W-1:0] sweep_addr,
    input  fbuf_pkg::word_t        sweep_din,
    output fbuf_pkg::word_t        sweep_dout
);

    localparam int DEPTH = 2 ** WORD_ADDR_W;

    // Word-organized storage, no reset on contents
    fbuf_pkg::word_t mem [DEPTH];

    // Host address split into word index and half select
    logic [WORD_ADDR_W-1:0] host_word;
    logic                   host_hi;

    assign host_word = host_addr[WORD_ADDR_W:1];
    // Odd half-word is the upper lane
    assign host_hi   = host_addr[0];

    // Both ports write from one process
    always_ff @(posedge a_clk) begin
        if (sweep_wr) begin
            mem[sweep_addr] <= sweep_din;
        end
        // Lane write, the other half of the word is kept
        if (host_wr) begin
            if (host_hi) begin
                mem[host_word][31:16] <= host_din;
            end else begin
                mem[host_word][15:0] <= host_din;
            end
        end
    end

    // Host read port, write data shows through on a write
    always_ff @(posedge a_clk) begin
        if (host_wr) begin
            host_dout <= host_din;
        end else if (host_hi) begin
            host_dout <= mem[host_word][31:16];
        end else begin
            host_dout <= mem[host_word][15:0];
        end
    end

    // Sweep read port, same write-through behavior
    always_ff @(posedge a_clk) begin
        if (sweep_wr) begin
            sweep_dout <= sweep_din;
        end else begin
            sweep_dout <= mem[sweep_addr];
        end
    end

    // Host and sweep must not write the same word together
    a_no_write_collision: assert property (@(posedge a_clk)
        !(host_wr && sweep_wr && (host_word == sweep_addr)));

endmodule

//--- logic/fbuf_host_port.sv
`timescale 1ns/1ps

module fbuf_host_port #(
    parameter int WORD_ADDR_W = 9
) (
    input  logic                 a_clk,
    input  logic                 reset,
    input  fbuf_pkg::pipe_in_t   pipe_in,
    input  logic                 pipe_out_read,
    output logic [WORD_ADDR_W:0] host_addr,
    output logic                 host_wr,
    input  fbuf_pkg::half_t      host_dout,
    output fbuf_pkg::half_t      pipe_out_data
);

    // Half-word pointers, one bit wider than the word address
    logic [WORD_ADDR_W:0] wr_ptr;
    logic [WORD_ADDR_W:0] rd_ptr;

    // Read strobe delayed to line up with RAM latency
    logic            rd_pending;
    // Last half-word handed to the host
    fbuf_pkg::half_t rd_hold;

    always_ff @(posedge a_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            rd_pending <= 1'b0;
            rd_hold    <= '0;
        end else begin
            if (pipe_in.write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pipe_out_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rd_pending <= pipe_out_read;
            // Keep the fresh word so it holds between strobes
            if (rd_pending) begin
                rd_hold <= host_dout;
            end
        end
    end

    // Write pointer wins the shared address when a write is present
    assign host_addr = pipe_in.write ? wr_ptr : rd_ptr;
    assign host_wr   = pipe_in.write;

    // Fresh RAM data in the cycle after the strobe, else the held value
    assign pipe_out_data = rd_pending ? host_dout : rd_hold;

    // The host never writes and reads in the same cycle
    a_no_rw_overlap: assert property (@(posedge a_clk) disable iff (reset)
        !(pipe_in.write && pipe_out_read));

endmodule

//--- logic/fbuf_sweep.sv
`timescale 1ns/1ps

module fbuf_sweep #(
    parameter int WORD_ADDR_W = 9
) (
    input  logic                   a_clk,
    input  logic                   reset,
    input  logic                   start,
    output logic [WORD_ADDR_W-1:0] sweep_addr,
    output logic                   sweep_wr,
    output logic                   busy,
    output logic                   done
);

    fbuf_pkg::sweep_state_e state;

    // Word currently being read or written
    logic [WORD_ADDR_W-1:0] index;
    logic                   last_index;

    assign last_index = &index;

    always_ff @(posedge a_clk) begin
        if (reset) begin
            state <= fbuf_pkg::IDLE;
            index <= '0;
        end else begin
            case (state)
                fbuf_pkg::IDLE: begin
                    // Start only counts while idle
                    if (start) begin
                        index <= '0;
                        state <= fbuf_pkg::READ;
                    end
                end
                fbuf_pkg::READ: begin
                    // RAM data lands at the end of this cycle
                    state <= fbuf_pkg::WRITE;
                end
                fbuf_pkg::WRITE: begin
                    if (last_index) begin
                        state <= fbuf_pkg::DONE;
                    end else begin
                        index <= index + 1'b1;
                        state <= fbuf_pkg::READ;
                    end
                end
                fbuf_pkg::DONE: begin
                    state <= fbuf_pkg::IDLE;
                end
                default: begin
                    state <= fbuf_pkg::IDLE;
                end
            endcase
        end
    end

    // Same address on both halves of a word's turn
    assign sweep_addr = index;
    assign sweep_wr   = (state == fbuf_pkg::WRITE);

    // busy drops as done pulses
    assign busy = (state == fbuf_pkg::READ) || (state == fbuf_pkg::WRITE);
    assign done = (state == fbuf_pkg::DONE);

    // Every write follows a read of the same word
    a_write_after_read: assert property (@(posedge a_clk) disable iff (reset)
        sweep_wr |-> ($past(state) == fbuf_pkg::READ) && $stable(sweep_addr));

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge a_clk) disable iff (reset)
        done |=> !done);

endmodule

//--- logic/fbuf_top.sv
`timescale 1ns/1ps

module fbuf_top #(
    parameter int WORD_ADDR_W = 9
) (
    input  logic               a_clk,
    input  logic               reset,
    input  fbuf_pkg::pipe_in_t pipe_in,
    input  logic               pipe_out_read,
    input  logic               start,
    output fbuf_pkg::half_t    pipe_out_data,
    output logic               busy,
    output logic               done
);

    // Host side of the RAM
    logic [WORD_ADDR_W:0] host_addr;
    logic                 host_wr;
    fbuf_pkg::half_t      host_dout;

    // Word side of the RAM
    logic [WORD_ADDR_W-1:0] sweep_addr;
    logic                   sweep_wr;
    fbuf_pkg::word_t        sweep_dout;
    fbuf_pkg::word_t        sweep_din;

    fbuf_host_port #(.WORD_ADDR_W(WORD_ADDR_W)) u_host_port (
        .a_clk         (a_clk),
        .reset         (reset),
        .pipe_in       (pipe_in),
        .pipe_out_read (pipe_out_read),
        .host_addr     (host_addr),
        .host_wr       (host_wr),
        .host_dout     (host_dout),
        .pipe_out_data (pipe_out_data)
    );

    fbuf_sweep #(.WORD_ADDR_W(WORD_ADDR_W)) u_sweep (
        .a_clk      (a_clk),
        .reset      (reset),
        .start      (start),
        .sweep_addr (sweep_addr),
        .sweep_wr   (sweep_wr),
        .busy       (busy),
        .done       (done)
    );

    // Host write data comes straight from the pipe
    fbuf_ram #(.WORD_ADDR_W(WORD_ADDR_W)) u_ram (
        .a_clk      (a_clk),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_din   (pipe_in.data),
        .host_dout  (host_dout),
        .sweep_wr   (sweep_wr),
        .sweep_addr (sweep_addr),
        .sweep_din  (sweep_din),
        .sweep_dout (sweep_dout)
    );

    // Read word goes through the doubler and back into the RAM
    fp_double u_fp_double (
        .value   (sweep_dout),
        .doubled (sweep_din)
    );

endmodule

//--- verif/fbuf_model.svh
`ifndef FBUF_MODEL_SVH
`define FBUF_MODEL_SVH

// IEEE-754 doubling of one single-precision word
function automatic fbuf_pkg::word_t double_ref(input fbuf_pkg::word_t w);
    fbuf_pkg::fp32_t f;
    f = w;
    // Zero, denormal, infinity and NaN come back as they were
    if (f.exponent == 8'h00 || f.exponent == 8'hff) begin
        return w;
    end
    // Largest finite exponent overflows to infinity, sign kept
    if (f.exponent == 8'hfe) begin
        return {f.sign, 8'hff, 23'd0};
    end
    // Times two on a normal number
    f.exponent = f.exponent + 8'd1;
    return f;
endfunction

// Half-word 2k is the low half of word k, 2k+1 the high half
function automatic fbuf_pkg::half_t half_of(input fbuf_pkg::word_t w, input logic upper);
    if (upper) begin
        return w[31:16];
    end
    return w[15:0];
endfunction

`endif

//--- verif/fbuf_tb.sv
`timescale 1ns/1ps

module fbuf_tb;

    localparam int WORDS = 512;
    localparam int HALVES = 2 * WORDS;
    localparam int SWEEP_CYCLES = 2 * WORDS + 1;
    localparam int RESET_CYCLES = 5;
    // Room for four fills, read-backs and sweeps
    localparam int TIMEOUT_CYCLES = 4 * (2 * HALVES + SWEEP_CYCLES);
    localparam int NUM_SPECIALS = 11;

    `include "fbuf_model.svh"

    // Zero, denormal, exponent 254, infinity, NaN, and exponent 253
    localparam fbuf_pkg::word_t SPECIALS [NUM_SPECIALS] = '{
        32'h0000_0000, 32'h8000_0000, 32'h0012_3456, 32'h8000_0001,
        32'h7f12_3456, 32'hff7f_ffff, 32'h7f80_0000, 32'hff80_0000,
        32'h7fc0_0000, 32'hff80_0001, 32'h7e80_0000
    };

    logic               a_clk = 1'b0;
    logic               reset = 1'b1;
    fbuf_pkg::pipe_in_t pipe_in = '0;
    logic               pipe_out_read = 1'b0;
    logic               start = 1'b0;
    fbuf_pkg::half_t    pipe_out_data;
    logic               busy;
    logic               done;

    integer          seed = 32'h489f_3ed0;
    int              cycle_count = 0;
    int              fail_count = 0;
    logic            read_seen = 1'b0;
    fbuf_pkg::half_t last_out = '0;
    // Expected buffer contents, one entry per word
    fbuf_pkg::word_t exp_word [WORDS];
    // Half-words still owed by outstanding read strobes
    fbuf_pkg::half_t expected_q [$];

    fbuf_top u_fbuf_top (
        .a_clk         (a_clk),
        .reset         (reset),
        .pipe_in       (pipe_in),
        .pipe_out_read (pipe_out_read),
        .start         (start),
        .pipe_out_data (pipe_out_data),
        .busy          (busy),
        .done          (done)
    );

    always #50 a_clk = ~a_clk;

    task automatic report_mismatch(input string name, input fbuf_pkg::word_t expected,
                                   input fbuf_pkg::word_t actual);
        fail_count++;
        $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("Some tests failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        fail_count++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    // Cycle count for sweep timing and the run limit
    always @(posedge a_clk) begin
        cycle_count <= cycle_count + 1;
        read_seen   <= pipe_out_read;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, the run did not finish",
                                     cycle_count));
        end
    end

    // Read data lands one cycle after its strobe, else the output holds
    always @(negedge a_clk) begin
        if (reset) begin
            last_out = '0;
        end else if (read_seen) begin
            if (expected_q.size() == 0) begin
                report_failure("Read data came back with no read strobe outstanding");
            end else begin
                assert (pipe_out_data == expected_q[0])
                    else report_mismatch("pipe_out_data", 32'(expected_q[0]),
                                         32'(pipe_out_data));
                last_out = expected_q.pop_front();
            end
        end else begin
            assert (pipe_out_data == last_out)
                else report_mismatch("pipe_out_data", 32'(last_out), 32'(pipe_out_data));
        end
    end

    task automatic make_pattern(input int special_at);
        int k;
        for (k = 0; k < WORDS; k++) begin
            exp_word[k] = $random(seed);
        end
        for (k = 0; k < NUM_SPECIALS; k++) begin
            exp_word[special_at + k] = SPECIALS[k];
        end
    endtask

    task automatic apply_reset();
        @(posedge a_clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge a_clk);
        reset <= 1'b0;
    endtask

    // Back-to-back write strobes over the whole buffer
    task automatic write_halves();
        int i;
        for (i = 0; i < HALVES; i++) begin
            @(posedge a_clk);
            pipe_in <= '{write: 1'b1, data: half_of(exp_word[i / 2], i[0])};
        end
        @(posedge a_clk);
        pipe_in <= '0;
    endtask

    // Back-to-back read strobes, then wait for the last data
    task automatic read_halves();
        int i;
        for (i = 0; i < HALVES; i++) begin
            @(posedge a_clk);
            pipe_out_read <= 1'b1;
            expected_q.push_back(half_of(exp_word[i / 2], i[0]));
        end
        @(posedge a_clk);
        pipe_out_read <= 1'b0;
        while (expected_q.size() != 0) @(negedge a_clk);
    endtask

    task automatic run_sweep(input bit extra_start);
        int start_cycle;
        int k;
        @(posedge a_clk);
        start <= 1'b1;
        @(negedge a_clk);
        start_cycle = cycle_count;
        assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        @(posedge a_clk);
        start <= 1'b0;
        @(negedge a_clk);
        assert (busy) else report_mismatch("busy", 32'd1, 32'(busy));
        // Start pulse in the middle of a sweep
        if (extra_start) begin
            repeat (WORDS / 2) @(posedge a_clk);
            start <= 1'b1;
            @(posedge a_clk);
            start <= 1'b0;
            @(negedge a_clk);
        end
        while (!done) begin
            assert (busy) else report_mismatch("busy", 32'd1, 32'(busy));
            @(negedge a_clk);
        end
        assert (cycle_count - start_cycle == SWEEP_CYCLES)
            else report_failure($sformatf("done came %0d cycles after start instead of %0d",
                                          cycle_count - start_cycle, SWEEP_CYCLES));
        assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        @(negedge a_clk);
        assert (!done) else report_mismatch("done", 32'd0, 32'(done));
        assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        for (k = 0; k < WORDS; k++) begin
            exp_word[k] = double_ref(exp_word[k]);
        end
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge a_clk);
        reset <= 1'b0;
        @(negedge a_clk);
        assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        assert (!done) else report_mismatch("done", 32'd0, 32'(done));
        assert (pipe_out_data == '0)
            else report_mismatch("pipe_out_data", 32'd0, 32'(pipe_out_data));

        // Plain fill and read-back
        make_pattern(0);
        write_halves();
        read_halves();

        // One sweep from rewound pointers, then check the doubled words
        apply_reset();
        run_sweep(1'b0);
        read_halves();

        // New data, a start pulse mid-sweep, then a second sweep with no refill
        make_pattern(WORDS - NUM_SPECIALS);
        write_halves();
        run_sweep(1'b1);
        apply_reset();
        run_sweep(1'b0);
        read_halves();

        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- fbuf.f
+incdir+verif
logic/fbuf_pkg.sv
logic/fp_double.sv
logic/fbuf_ram.sv
logic/fbuf_host_port.sv
logic/fbuf_sweep.sv
logic/fbuf_top.sv
verif/fbuf_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module fbuf_tb -f fbuf.f -o fbuf_sim
	-./obj_dir/fbuf_sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
